//--- compile.f
+incdir+src
src/fetch_pkg.sv
src/line_fill_if.sv
src/fetch_req_decode.sv
src/axi_read_engine.sv
src/line_result.sv
src/fetch_port_top.sv
test/axi_mem_model.sv
test/fetch_port_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module fetch_port_tb --Mdir obj_dir -o fetch_port_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fetch_port_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^test passed$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- test/fetch_port_tb.sv
`include "fetch_defines.svh"

module fetch_port_tb;

    localparam integer      NUM_REQ     = 200;
    localparam integer      WAIT_LIMIT  = 100;      // cycles per wait
    localparam integer      SEED_INIT   = 32'hfd0279db;
    localparam logic [63:0] CONTENT_KEY = 64'h5a5a_0000_c3c3_0000;
    localparam logic [63:0] POOL_BASE   = 64'h0000_0012_3400_0000; // 8 lines around here

    logic        clock;
    logic        reset;
    logic        fetch_valid;
    logic [63:0] fetch_addr;
    logic        fetch_ready;
    logic [63:0] fetch_data;
    logic        fetch_err;

    logic        axi_ar_valid;
    logic        axi_ar_ready;
    logic [63:0] axi_ar_addr;
    logic [3:0]  axi_ar_id;
    logic [7:0]  axi_ar_len;
    logic [2:0]  axi_ar_size;
    logic [1:0]  axi_ar_burst;
    logic        axi_ar_lock;
    logic [3:0]  axi_ar_cache;
    logic [2:0]  axi_ar_prot;
    logic        axi_r_valid;
    logic        axi_r_ready;
    logic [63:0] axi_r_data;
    logic [1:0]  axi_r_resp;
    logic        axi_r_last;

    logic [31:0] ar_count;   // AR handshakes seen by the slave
    logic [63:0] ar_addr;
    logic [7:0]  ar_len;
    logic [2:0]  ar_size;
    logic [1:0]  ar_burst;

    integer      seed;
    logic [58:0] model_tag;    // line the port should hold
    logic        model_vld;
    logic [58:0] last_err_tag; // line of the previous failed fill
    logic        last_err_vld;
    logic [2:0]  line_sel;
    logic [63:0] req_addr;
    integer      hit_cnt;
    integer      miss_cnt;
    integer      err_cnt;
    integer      err_repeat_cnt;
    integer      i;

    always #2 clock = ~clock;

    fetch_port_top i_fetch_port_top (
        .clock (clock), .reset (reset),
        .fetch_valid_i (fetch_valid), .fetch_addr_i (fetch_addr),
        .fetch_ready_o (fetch_ready), .fetch_data_o (fetch_data), .fetch_err_o (fetch_err),
        .axi_ar_valid_o (axi_ar_valid), .axi_ar_ready_i (axi_ar_ready),
        .axi_ar_addr_o (axi_ar_addr), .axi_ar_id_o (axi_ar_id), .axi_ar_len_o (axi_ar_len),
        .axi_ar_size_o (axi_ar_size), .axi_ar_burst_o (axi_ar_burst),
        .axi_ar_lock_o (axi_ar_lock), .axi_ar_cache_o (axi_ar_cache),
        .axi_ar_prot_o (axi_ar_prot),
        .axi_r_valid_i (axi_r_valid), .axi_r_ready_o (axi_r_ready),
        .axi_r_data_i (axi_r_data), .axi_r_resp_i (axi_r_resp), .axi_r_last_i (axi_r_last)
    );

    // slave draws its stalls from the same seed
    axi_mem_model #(.SEED (SEED_INIT)) i_axi_mem_model (
        .clock (clock), .reset (reset),
        .axi_ar_valid_i (axi_ar_valid), .axi_ar_ready_o (axi_ar_ready),
        .axi_ar_addr_i (axi_ar_addr), .axi_ar_len_i (axi_ar_len),
        .axi_ar_size_i (axi_ar_size), .axi_ar_burst_i (axi_ar_burst),
        .axi_r_valid_o (axi_r_valid), .axi_r_ready_i (axi_r_ready),
        .axi_r_data_o (axi_r_data), .axi_r_resp_o (axi_r_resp), .axi_r_last_o (axi_r_last),
        .ar_count_o (ar_count), .ar_addr_o (ar_addr), .ar_len_o (ar_len),
        .ar_size_o (ar_size), .ar_burst_o (ar_burst)
    );

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // half the time stay on the last line, so hits and repeats show up
    task automatic pick_addr(output logic [63:0] addr);
        logic [1:0] word;
        if (($random(seed) & 1) == 0) line_sel = 3'($random(seed) & 7);
        word = 2'($random(seed) & 3);
        addr = POOL_BASE | (64'(line_sel[2]) << 12) | (64'(line_sel[1:0]) << 8)
             | (64'(word) << 3);   // bit 12 lines fail
    endtask

    task automatic issue_fetch(input logic [63:0] addr);
        logic [58:0] tag;
        logic        expect_hit;
        logic        expect_err;
        logic [31:0] ar_before;
        logic        ar_seen;
        integer      cycles;
        tag        = addr[63:5];
        expect_hit = model_vld && (tag == model_tag);
        expect_err = !expect_hit && addr[12];
        ar_before  = ar_count;
        ar_seen    = 1'b0;
        cycles     = 0;
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        do begin
            @(negedge clock);
            cycles = cycles + 1;
            if (cycles == 1) check_value("axi_ar_valid_o", 64'(axi_ar_valid), 64'(!expect_hit));
            if (cycles == 1 && axi_ar_valid) begin   // fixed AR fields, id always zero
                check_value("axi_ar_id_o", 64'(axi_ar_id), 64'd0);
                check_value("axi_ar_lock_o", 64'(axi_ar_lock), 64'd0);
                check_value("axi_ar_cache_o", 64'(axi_ar_cache), 64'h2);
                check_value("axi_ar_prot_o", 64'(axi_ar_prot), 64'h4); // instruction access
            end
            if (axi_ar_valid) ar_seen = 1'b1;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: no fetch_ready_o for request %0d at %h", i, addr);
                $display("test failed");
                $fatal(1);
            end
        end while (!fetch_ready);

        check_value("fetch_data_o", fetch_data, addr ^ CONTENT_KEY);
        check_value("fetch_err_o", 64'(fetch_err), 64'(expect_err));
        if (expect_hit) begin
            hit_cnt = hit_cnt + 1;
            check_value("hit latency", 64'(cycles), 64'd1);
            check_value("arvalid during hit", 64'(ar_seen), 64'd0);
            check_value("ar count on hit", 64'(ar_count), 64'(ar_before));
        end else begin
            miss_cnt = miss_cnt + 1;
            check_value("ar count on miss", 64'(ar_count), 64'(ar_before + 1));
            check_value("axi_ar_addr_o", ar_addr, {tag, 5'b0});
            check_value("axi_ar_len_o", 64'(ar_len), 64'd3);
            check_value("axi_ar_burst_o", 64'(ar_burst), 64'd1);   // INCR
            check_value("axi_ar_size_o", 64'(ar_size), 64'd3);     // 8 byte beats
            if (expect_err) begin
                err_cnt = err_cnt + 1;
                if (last_err_vld && last_err_tag == tag) err_repeat_cnt = err_repeat_cnt + 1;
            end
            model_vld    = !expect_err;     // failed line is not kept
            model_tag    = tag;
            last_err_vld = expect_err;
            last_err_tag = tag;
        end

        // request stays up through the answer cycle, port must not take it twice
        @(negedge clock);
        check_value("fetch_ready_o after answer", 64'(fetch_ready), 64'd0);
        check_value("axi_ar_valid_o after answer", 64'(axi_ar_valid), 64'd0);
        fetch_valid = 1'b0;
    endtask

    initial begin
        seed           = SEED_INIT;
        clock          = 1'b0;
        reset          = 1'b0;
        fetch_valid    = 1'b0;
        fetch_addr     = '0;
        model_tag      = '0;
        model_vld      = 1'b0;
        last_err_tag   = '0;
        last_err_vld   = 1'b0;
        line_sel       = '0;
        hit_cnt        = 0;
        miss_cnt       = 0;
        err_cnt        = 0;
        err_repeat_cnt = 0;

        repeat (3) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        check_value("fetch_ready_o", 64'(fetch_ready), 64'd0);   // idle after reset
        check_value("axi_ar_valid_o", 64'(axi_ar_valid), 64'd0);
        check_value("axi_r_ready_o", 64'(axi_r_ready), 64'd0);

        for (i = 0; i < NUM_REQ; i = i + 1) begin
            pick_addr(req_addr);
            issue_fetch(req_addr);
        end

        // the mix must have reached every kind of request
        check_value("hits seen", 64'(hit_cnt > 0), 64'd1);
        check_value("misses seen", 64'(miss_cnt > 0), 64'd1);
        check_value("error lines seen", 64'(err_cnt > 0), 64'd1);
        check_value("repeated error lines seen", 64'(err_repeat_cnt > 0), 64'd1);
        $display("hits %0d, misses %0d, error lines %0d, repeated error lines %0d",
                 hit_cnt, miss_cnt, err_cnt, err_repeat_cnt);
        $display("test passed");
        $finish;
    end

endmodule

//--- test/axi_mem_model.sv
`include "fetch_defines.svh"

// AXI4 read slave for the fetch port testbench, random stalls on AR and R
module axi_mem_model #(
    parameter integer SEED = 0
) (
    input  logic                     clock,
    input  logic                     reset,

    input  logic                     axi_ar_valid_i,
    output logic                     axi_ar_ready_o,
    input  logic [`FETCH_ADDR_W-1:0] axi_ar_addr_i,
    input  logic [7:0]               axi_ar_len_i,
    input  logic [2:0]               axi_ar_size_i,
    input  logic [1:0]               axi_ar_burst_i,

    output logic                     axi_r_valid_o,
    input  logic                     axi_r_ready_i,
    output logic [`FETCH_DATA_W-1:0] axi_r_data_o,
    output logic [1:0]               axi_r_resp_o,
    output logic                     axi_r_last_o,

    // record of the AR handshakes, for the testbench checks
    output logic [31:0]              ar_count_o,
    output logic [`FETCH_ADDR_W-1:0] ar_addr_o,
    output logic [7:0]               ar_len_o,
    output logic [2:0]               ar_size_o,
    output logic [1:0]               ar_burst_o
);

    localparam logic [63:0] CONTENT_KEY = 64'h5a5a_0000_c3c3_0000;

    integer      seed;
    integer      ar_delay;      // cycles left before arready
    integer      r_delay;       // cycles left before the next rvalid
    integer      beat;          // beats done in the current burst
    logic        burst_on;
    logic [63:0] burst_addr;
    logic        ar_seen;       // arvalid shown to the coming edge
    logic        r_seen;        // rready shown to the coming edge

    initial begin
        seed           = SEED;
        ar_delay       = 0;
        r_delay        = 0;
        beat           = 0;
        burst_on       = 1'b0;
        burst_addr     = '0;
        ar_seen        = 1'b0;
        r_seen         = 1'b0;
        axi_ar_ready_o = 1'b0;
        axi_r_valid_o  = 1'b0;
        axi_r_data_o   = '0;
        axi_r_resp_o   = 2'b00;
        axi_r_last_o   = 1'b0;
    end

    // each falling edge settles the handshakes of the rising edge before it,
    // then sets up the slave side for the next rising edge
    always @(negedge clock) begin
        if (!reset) begin
            burst_on       = 1'b0;
            beat           = 0;
            ar_seen        = 1'b0;
            r_seen         = 1'b0;
            axi_ar_ready_o = 1'b0;
            axi_r_valid_o  = 1'b0;
            axi_r_last_o   = 1'b0;
            ar_count_o    <= '0;
        end else begin
            if (ar_seen && axi_ar_ready_o) begin   // AR taken
                burst_on    = 1'b1;
                burst_addr  = ar_addr_o;
                beat        = 0;
                r_delay     = $random(seed) & 3;
                ar_count_o <= ar_count_o + 1;
            end
            if (r_seen && axi_r_valid_o) begin     // beat taken
                beat    = beat + 1;
                r_delay = $random(seed) & 3;
                if (beat == `FETCH_LINE_BEATS) burst_on = 1'b0;
            end

            axi_ar_ready_o = 1'b0;
            if (!burst_on && axi_ar_valid_i) begin
                if (ar_delay == 0) begin
                    axi_ar_ready_o = 1'b1;
                    ar_delay       = $random(seed) & 3;
                end else begin
                    ar_delay = ar_delay - 1;
                end
            end

            axi_r_valid_o = 1'b0;
            axi_r_last_o  = 1'b0;
            if (burst_on) begin
                if (r_delay == 0) begin   // stays up until taken
                    axi_r_valid_o = 1'b1;
                    axi_r_data_o  = (burst_addr + 64'(beat * 8)) ^ CONTENT_KEY;
                    axi_r_resp_o  = (burst_addr[12] && beat == 1) ? 2'b10 : 2'b00; // SLVERR
                    axi_r_last_o  = (beat == `FETCH_LINE_BEATS - 1);
                end else begin
                    r_delay = r_delay - 1;
                end
            end

            ar_seen = axi_ar_valid_i;
            r_seen  = axi_r_ready_i;
            if (axi_ar_valid_i) begin
                ar_addr_o  <= axi_ar_addr_i;
                ar_len_o   <= axi_ar_len_i;
                ar_size_o  <= axi_ar_size_i;
                ar_burst_o <= axi_ar_burst_i;
            end
        end
    end

endmodule

//--- src/fetch_port_top.sv
`include "fetch_defines.svh"

module fetch_port_top (
    input  logic                       clock,
    input  logic                       reset,

    // fetch requester
    input  logic                       fetch_valid_i,
    input  logic [`FETCH_ADDR_W-1:0]   fetch_addr_i,
    output logic                       fetch_ready_o,
    output logic [`FETCH_DATA_W-1:0]   fetch_data_o,
    output logic                       fetch_err_o,

    // AXI4 read, AR
    output logic                       axi_ar_valid_o,
    input  logic                       axi_ar_ready_i,
    output logic [`FETCH_ADDR_W-1:0]   axi_ar_addr_o,
    output logic [`FETCH_AXI_ID_W-1:0] axi_ar_id_o,
    output logic [7:0]                 axi_ar_len_o,
    output logic [2:0]                 axi_ar_size_o,
    output logic [1:0]                 axi_ar_burst_o,
    output logic                       axi_ar_lock_o,
    output logic [3:0]                 axi_ar_cache_o,
    output logic [2:0]                 axi_ar_prot_o,

    // AXI4 read, R
    input  logic                       axi_r_valid_i,
    output logic                       axi_r_ready_o,
    input  logic [`FETCH_DATA_W-1:0]   axi_r_data_i,
    input  logic [1:0]                 axi_r_resp_i,
    input  logic                       axi_r_last_i
);

    logic                 miss_valid;
    fetch_pkg::tag_t      miss_tag;
    logic                 hit;
    fetch_pkg::beat_idx_t word_idx;

    line_fill_if i_line_fill ();   // beats from engine to buffer and tag keeper

    fetch_req_decode i_fetch_req_decode (
        .clock         (clock),
        .reset         (reset),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .miss_valid_o  (miss_valid),
        .miss_tag_o    (miss_tag),
        .hit_o         (hit),
        .word_idx_o    (word_idx),
        .fill          (i_line_fill.decode)
    );

    // fill end is seen by the decoder through beat_last, fill_done stays local
    axi_read_engine i_axi_read_engine (
        .clock          (clock),
        .reset          (reset),
        .miss_valid_i   (miss_valid),
        .miss_tag_i     (miss_tag),
        .fill_done_o    (),
        .fill           (i_line_fill.engine),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_addr_o  (axi_ar_addr_o),
        .axi_ar_id_o    (axi_ar_id_o),
        .axi_ar_len_o   (axi_ar_len_o),
        .axi_ar_size_o  (axi_ar_size_o),
        .axi_ar_burst_o (axi_ar_burst_o),
        .axi_ar_lock_o  (axi_ar_lock_o),
        .axi_ar_cache_o (axi_ar_cache_o),
        .axi_ar_prot_o  (axi_ar_prot_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_ready_o  (axi_r_ready_o),
        .axi_r_data_i   (axi_r_data_i),
        .axi_r_resp_i   (axi_r_resp_i),
        .axi_r_last_i   (axi_r_last_i)
    );

    line_result i_line_result (
        .clock         (clock),
        .reset         (reset),
        .hit_i         (hit),
        .word_idx_i    (word_idx),
        .fill          (i_line_fill.result),
        .fetch_ready_o (fetch_ready_o),
        .fetch_data_o  (fetch_data_o),
        .fetch_err_o   (fetch_err_o)
    );

endmodule

//--- src/line_result.sv
`include "fetch_defines.svh"

module line_result (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 hit_i,          // answer from buffer this cycle
    input  fetch_pkg::beat_idx_t word_idx_i,     // requested word in line
    line_fill_if.result          fill,
    output logic                 fetch_ready_o,
    output fetch_pkg::word_t     fetch_data_o,
    output logic                 fetch_err_o
);

    fetch_pkg::word_t line_buf [`FETCH_LINE_BEATS];  // one 32 byte line
    logic             miss_ans;   // answer cycle after the rlast beat
    logic             err_q;      // error state of the finished burst

    // every beat lands in its slot, also on error bursts
    always_ff @(posedge clock) begin
        if (fill.beat_valid) begin
            line_buf[fill.beat_idx] <= fill.beat_data;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            miss_ans <= 1'b0;
        end else begin
            miss_ans <= fill.beat_last;
        end
    end

    always_ff @(posedge clock) begin
        if (fill.beat_last) begin
            err_q <= fill.beat_err;
        end
    end

    // line complete by now, so hit and miss read the same way
    assign fetch_ready_o = hit_i | miss_ans;
    assign fetch_data_o  = line_buf[word_idx_i];
    assign fetch_err_o   = miss_ans & err_q;   // hits come from clean lines only

    // one answer per request, the requester needs a cycle to move on
    a_ready_pulse: assert property (
        @(posedge clock) disable iff (!reset)
        fetch_ready_o |=> !fetch_ready_o
    );

    // buffer hits cannot overlap the end of a fill
    a_no_overlap: assert property (
        @(posedge clock) disable iff (!reset)
        !(hit_i && miss_ans)
    );

endmodule

//--- src/axi_read_engine.sv
`include "fetch_defines.svh"

module axi_read_engine (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       miss_valid_i,
    input  fetch_pkg::tag_t            miss_tag_i,
    output logic                       fill_done_o,    // pulse after the rlast beat
    line_fill_if.engine                fill,

    // AR channel
    output logic                       axi_ar_valid_o,
    input  logic                       axi_ar_ready_i,
    output logic [`FETCH_ADDR_W-1:0]   axi_ar_addr_o,
    output logic [`FETCH_AXI_ID_W-1:0] axi_ar_id_o,
    output logic [7:0]                 axi_ar_len_o,
    output logic [2:0]                 axi_ar_size_o,
    output logic [1:0]                 axi_ar_burst_o,
    output logic                       axi_ar_lock_o,
    output logic [3:0]                 axi_ar_cache_o,
    output logic [2:0]                 axi_ar_prot_o,

    // R channel
    input  logic                       axi_r_valid_i,
    output logic                       axi_r_ready_o,
    input  logic [`FETCH_DATA_W-1:0]   axi_r_data_i,
    input  logic [1:0]                 axi_r_resp_i,
    input  logic                       axi_r_last_i
);

    fetch_pkg::rd_state_e state_q, state_d;
    fetch_pkg::tag_t      tag_q;      // line being fetched
    fetch_pkg::beat_idx_t beat_cnt;   // next beat slot
    logic                 err_acc;    // bad response seen earlier in burst
    logic                 beat_take;
    logic                 resp_bad;

    assign beat_take = (state_q == fetch_pkg::R_WAIT) && axi_r_valid_i;
    assign resp_bad  = fetch_pkg::rresp_e'(axi_r_resp_i) != fetch_pkg::OKAY;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= fetch_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE:    if (miss_valid_i) state_d = fetch_pkg::AR_WAIT;
            fetch_pkg::AR_WAIT: if (axi_ar_ready_i) state_d = fetch_pkg::R_WAIT;
            fetch_pkg::R_WAIT:  if (beat_take && axi_r_last_i) state_d = fetch_pkg::IDLE;
            default:            state_d = fetch_pkg::IDLE;
        endcase
    end

    // tag latched at launch, holds araddr steady through AR_WAIT
    always_ff @(posedge clock) begin
        if (state_q == fetch_pkg::IDLE && miss_valid_i) begin
            tag_q <= miss_tag_i;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            beat_cnt    <= '0;
            err_acc     <= 1'b0;
            fill_done_o <= 1'b0;
        end else begin
            fill_done_o <= beat_take && axi_r_last_i;
            if (axi_ar_valid_o && axi_ar_ready_i) begin
                beat_cnt <= '0;     // fresh burst
                err_acc  <= 1'b0;
            end else if (beat_take) begin
                beat_cnt <= beat_cnt + 1'b1;
                err_acc  <= err_acc | resp_bad;
            end
        end
    end

    assign axi_ar_valid_o = (state_q == fetch_pkg::AR_WAIT);
    assign axi_ar_addr_o  = {tag_q, {`FETCH_LINE_OFF_W{1'b0}}};  // line aligned
    assign axi_ar_id_o    = '0;
    assign axi_ar_len_o   = 8'(`FETCH_LINE_BEATS - 1);
    assign axi_ar_size_o  = `FETCH_AXI_SIZE;
    assign axi_ar_burst_o = `FETCH_AXI_BURST_INCR;
    assign axi_ar_lock_o  = 1'b0;
    assign axi_ar_cache_o = `FETCH_AXI_CACHE;
    assign axi_ar_prot_o  = `FETCH_AXI_PROT;
    assign axi_r_ready_o  = (state_q == fetch_pkg::R_WAIT);

    assign fill.beat_valid = beat_take;
    assign fill.beat_data  = axi_r_data_i;
    assign fill.beat_idx   = beat_cnt;
    assign fill.beat_last  = beat_take && axi_r_last_i;
    assign fill.beat_err   = err_acc | (beat_take & resp_bad);  // includes this beat
    assign fill.fill_tag   = tag_q;

    // slave may stall arready, the request must not move meanwhile
    a_ar_stable: assert property (
        @(posedge clock) disable iff (!reset)
        axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_addr_o)
    );

    // rlast exactly on the fourth beat
    a_rlast_pos: assert property (
        @(posedge clock) disable iff (!reset)
        beat_take |-> (axi_r_last_i == (beat_cnt == fetch_pkg::beat_idx_t'(`FETCH_LINE_BEATS - 1)))
    );

endmodule

//--- src/fetch_req_decode.sv
`include "fetch_defines.svh"

module fetch_req_decode (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 fetch_valid_i,
    input  fetch_pkg::addr_t     fetch_addr_i,
    output logic                 miss_valid_o,   // one cycle launch pulse
    output fetch_pkg::tag_t      miss_tag_o,
    output logic                 hit_o,          // registered hit, answer cycle
    output fetch_pkg::beat_idx_t word_idx_o,     // word of the request in flight
    line_fill_if.decode          fill
);

    fetch_pkg::tag_t line_tag;   // line held by the buffer
    logic            line_vld;
    fetch_pkg::tag_t req_tag;
    logic            req_hit;
    logic            accept;     // request sampled this edge
    logic            busy;       // miss outstanding
    logic            hold;       // answer cycle, requester still shows old request
    logic            fill_ok;

    assign req_tag = fetch_addr_i[`FETCH_ADDR_W-1:`FETCH_LINE_OFF_W];
    assign req_hit = line_vld && (req_tag == line_tag);
    assign accept  = fetch_valid_i && !busy && !hold;
    assign fill_ok = fill.beat_last && !fill.beat_err; // clean end of burst

    assign miss_valid_o = accept && !req_hit;
    assign miss_tag_o   = req_tag;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            hit_o    <= 1'b0;
            hold     <= 1'b0;
            busy     <= 1'b0;
            line_vld <= 1'b0;
        end else begin
            hit_o <= accept && req_hit;
            hold  <= (accept && req_hit) || fill.beat_last;  // skip the answer cycle
            if (miss_valid_o) begin
                busy     <= 1'b1;
                line_vld <= 1'b0;    // buffer is about to be overwritten
            end else if (fill.beat_last) begin
                busy     <= 1'b0;
                line_vld <= fill_ok; // error lines stay invalid
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill_ok) begin
            line_tag <= fill.fill_tag;
        end
        if (accept) begin
            word_idx_o <= fetch_addr_i[`FETCH_LINE_OFF_W-1:`FETCH_WORD_OFF_W];
        end
    end

    // a fill only ends for a miss launched here
    a_fill_launched: assert property (
        @(posedge clock) disable iff (!reset)
        fill.beat_last |-> busy
    );

endmodule

//--- src/line_fill_if.sv
// burst beats from the read engine to the line buffer and the tag keeper
interface line_fill_if;

    logic               beat_valid;  // beat taken on R this cycle
    fetch_pkg::word_t   beat_data;
    fetch_pkg::beat_idx_t beat_idx;  // slot the beat lands in
    logic               beat_last;   // beat carried rlast
    logic               beat_err;    // any bad rresp in this burst so far
    fetch_pkg::tag_t    fill_tag;    // line being filled

    modport engine (
        output beat_valid,
        output beat_data,
        output beat_idx,
        output beat_last,
        output beat_err,
        output fill_tag
    );

    modport result (
        input beat_valid,
        input beat_data,
        input beat_idx,
        input beat_last,
        input beat_err
    );

    // decoder only cares how and where a fill ends
    modport decode (
        input beat_last,
        input beat_err,
        input fill_tag
    );

endinterface

//--- src/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_W-1:0] addr_t;    // byte address
    typedef logic [`FETCH_DATA_W-1:0] word_t;    // one fetch word or one R beat

    // line address, byte address without the in-line offset
    typedef logic [`FETCH_ADDR_W-`FETCH_LINE_OFF_W-1:0] tag_t;

    typedef logic [$clog2(`FETCH_LINE_BEATS)-1:0] beat_idx_t; // word slot in line

    // AXI rresp encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } rresp_e;

    // read engine states
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        AR_WAIT = 2'b01,    // arvalid up, waiting for arready
        R_WAIT  = 2'b10     // rready up, collecting beats
    } rd_state_e;

endpackage

//--- src/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// fetch word and bus geometry
`define FETCH_DATA_W         64      // word and beat width
`define FETCH_ADDR_W         64      // byte address width
`define FETCH_LINE_BEATS     4       // words per line, arlen is this minus one
`define FETCH_WORD_OFF_W     3       // byte offset inside a word
`define FETCH_LINE_OFF_W     5       // byte offset inside a 32 byte line

// fixed AR channel fields
`define FETCH_AXI_ID_W       4       // id is always zero
`define FETCH_AXI_SIZE       3'b011  // 8 bytes per beat
`define FETCH_AXI_BURST_INCR 2'b01
`define FETCH_AXI_CACHE      4'b0010 // normal, non-cacheable, non-bufferable
`define FETCH_AXI_PROT       3'b100  // instruction, secure, unprivileged

`endif
